//--- riscv_isa_pkg.sv
package riscv_isa_pkg;

    // Data and register widths
    localparam int xlen = 32;

    typedef logic [4:0]      reg_index_t;
    typedef logic [xlen-1:0] word_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    // funct3 for arithmetic and shifts
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for loads and stores
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // funct7, also the shift-type bits of the immediate shifts
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Operations the core executes
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
        OP_SLTIU, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW
    } op_t;

endpackage

//--- core_pkg.sv
package core_pkg;

    // Instruction stages, one instruction in flight
    typedef enum logic [2:0] {
        STAGE_FETCH,
        STAGE_DECODE,
        STAGE_EXECUTE,
        STAGE_MEMORY,
        STAGE_WRITEBACK
    } stage_t;

    // Wishbone byte lanes
    localparam int sel_width = 4;
    localparam int byte_bits = 8;

    typedef logic [sel_width-1:0] sel_t;

endpackage

//--- instr_decoder.sv
module instr_decoder (
    input  riscv_isa_pkg::word_t      instr,
    output riscv_isa_pkg::op_t        op,
    output riscv_isa_pkg::reg_index_t rs1,
    output riscv_isa_pkg::reg_index_t rs2,
    output riscv_isa_pkg::reg_index_t rd,
    output riscv_isa_pkg::word_t      imm,
    output logic                      writes_rd
);
    import riscv_isa_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      s_imm;
    word_t      u_imm;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // Immediate formats, sign taken from bit 31
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign u_imm = {instr[31:12], 12'b0};

    always_comb begin
        op  = OP_NONE;
        imm = i_imm;
        rs1 = instr[19:15];
        rs2 = '0;
        case (opcode)
            OPC_OP: begin
                rs2 = instr[24:20];
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: op = OP_ADD;
                        F3_SLL:     op = OP_SLL;
                        F3_SLT:     op = OP_SLT;
                        F3_SLTU:    op = OP_SLTU;
                        F3_XOR:     op = OP_XOR;
                        F3_SRL_SRA: op = OP_SRL;
                        F3_OR:      op = OP_OR;
                        default:    op = OP_AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    // Only ADD and SRL have an alternate form
                    if (funct3 == F3_ADD_SUB)
                        op = OP_SUB;
                    else if (funct3 == F3_SRL_SRA)
                        op = OP_SRA;
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: op = OP_ADDI;
                    F3_SLT:     op = OP_SLTI;
                    F3_SLTU:    op = OP_SLTIU;
                    F3_XOR:     op = OP_XORI;
                    F3_OR:      op = OP_ORI;
                    F3_AND:     op = OP_ANDI;
                    F3_SLL:     op = (funct7 == F7_BASE) ? OP_SLLI : OP_NONE;
                    default: begin
                        if (funct7 == F7_BASE)
                            op = OP_SRLI;
                        else if (funct7 == F7_ALT)
                            op = OP_SRAI;
                    end
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_LB:   op = OP_LB;
                    F3_LH:   op = OP_LH;
                    F3_LW:   op = OP_LW;
                    F3_LBU:  op = OP_LBU;
                    F3_LHU:  op = OP_LHU;
                    default: op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                imm = s_imm;
                rs2 = instr[24:20];
                case (funct3)
                    F3_SB:   op = OP_SB;
                    F3_SH:   op = OP_SH;
                    F3_SW:   op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            OPC_LUI: begin
                imm = u_imm;
                rs1 = '0;
                op  = OP_LUI;
            end
            default: rs1 = '0;
        endcase
    end

    // Stores and unknown encodings leave the register file alone
    assign writes_rd = !(op inside {OP_NONE, OP_SB, OP_SH, OP_SW});

endmodule

//--- register_file.sv
module register_file (
    input  logic                      clk,
    input  logic                      reset,
    input  riscv_isa_pkg::reg_index_t rs1,
    input  riscv_isa_pkg::reg_index_t rs2,
    input  riscv_isa_pkg::reg_index_t rd,
    input  logic                      rd_we,
    input  riscv_isa_pkg::word_t      rd_val,
    output riscv_isa_pkg::word_t      rs1_val,
    output riscv_isa_pkg::word_t      rs2_val
);
    import riscv_isa_pkg::*;

    localparam int reg_count = 2 ** $bits(reg_index_t);

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
            rs1_val <= '0;
            rs2_val <= '0;
        end else begin
            // x0 is never written
            if (rd_we && rd != '0)
                regs[rd] <= rd_val;
            // Registered reads, x0 forced to zero
            rs1_val <= (rs1 == '0) ? '0 : regs[rs1];
            rs2_val <= (rs2 == '0) ? '0 : regs[rs2];
        end
    end

endmodule

//--- alu.sv
module alu (
    input  riscv_isa_pkg::op_t   op,
    input  riscv_isa_pkg::word_t rs1_val,
    input  riscv_isa_pkg::word_t rs2_val,
    input  riscv_isa_pkg::word_t imm,
    output riscv_isa_pkg::word_t result
);
    import riscv_isa_pkg::*;

    logic       reg_form;
    word_t      operand_b;
    logic [4:0] shamt;

    // Register forms take rs2, everything else the immediate
    assign reg_form = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                 OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    assign operand_b = reg_form ? rs2_val : imm;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI:
                result = rs1_val + operand_b;
            OP_SUB:
                result = rs1_val - operand_b;
            OP_AND, OP_ANDI:
                result = rs1_val & operand_b;
            OP_OR, OP_ORI:
                result = rs1_val | operand_b;
            OP_XOR, OP_XORI:
                result = rs1_val ^ operand_b;
            OP_SLL, OP_SLLI:
                result = rs1_val << shamt;
            OP_SRL, OP_SRLI:
                result = rs1_val >> shamt;
            OP_SRA, OP_SRAI:
                result = word_t'($signed(rs1_val) >>> shamt);
            OP_SLT, OP_SLTI:
                result = word_t'($signed(rs1_val) < $signed(operand_b));
            OP_SLTU, OP_SLTIU:
                result = word_t'(rs1_val < operand_b);
            OP_LUI:
                result = imm;
            // Effective address for loads and stores
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW:
                result = rs1_val + imm;
            default:
                result = '0;
        endcase
    end

endmodule

//--- load_store_unit.sv
module load_store_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_start,
    input  riscv_isa_pkg::op_t   op,
    input  riscv_isa_pkg::word_t result,
    input  riscv_isa_pkg::word_t rs2_val,
    output logic                 dbus_cyc,
    output logic                 dbus_stb,
    output logic                 dbus_we,
    output core_pkg::sel_t       dbus_sel,
    output riscv_isa_pkg::word_t dbus_adr,
    output riscv_isa_pkg::word_t dbus_wdat,
    input  riscv_isa_pkg::word_t dbus_rdat,
    input  logic                 dbus_ack,
    output logic                 mem_done,
    output riscv_isa_pkg::word_t rd_val
);
    import riscv_isa_pkg::*;
    import core_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       pass_done;
    logic [1:0] lane_offset;
    sel_t       lane_sel;
    word_t      load_word;
    word_t      load_val;

    assign is_load  = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign is_store = op inside {OP_SB, OP_SH, OP_SW};

    // Byte lanes from access size and low address bits
    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_SB: lane_sel = sel_t'(4'b0001 << result[1:0]);
            OP_LH, OP_LHU, OP_SH: lane_sel = sel_t'(4'b0011 << result[1:0]);
            default:              lane_sel = 4'b1111;
        endcase
    end

    // Move the addressed lanes down, then extend
    always_comb begin
        load_word = dbus_rdat >> (lane_offset * byte_bits);
        case (op)
            OP_LB:
                load_val = {{(xlen-byte_bits){load_word[byte_bits-1]}},
                            load_word[byte_bits-1:0]};
            OP_LBU:
                load_val = {{(xlen-byte_bits){1'b0}}, load_word[byte_bits-1:0]};
            OP_LH:
                load_val = {{(xlen-2*byte_bits){load_word[2*byte_bits-1]}},
                            load_word[2*byte_bits-1:0]};
            OP_LHU:
                load_val = {{(xlen-2*byte_bits){1'b0}}, load_word[2*byte_bits-1:0]};
            default:
                load_val = load_word;
        endcase
    end

    // Bus control
    always_ff @(posedge clk) begin
        if (reset) begin
            dbus_cyc  <= 1'b0;
            dbus_stb  <= 1'b0;
            dbus_we   <= 1'b0;
            pass_done <= 1'b0;
        end else begin
            pass_done <= mem_start && !is_load && !is_store;
            if (mem_start && (is_load || is_store)) begin
                dbus_cyc <= 1'b1;
                dbus_stb <= 1'b1;
                dbus_we  <= is_store;
            end else if (dbus_cyc && dbus_ack) begin
                dbus_cyc <= 1'b0;
                dbus_stb <= 1'b0;
                dbus_we  <= 1'b0;
            end
        end
    end

    // Address, lanes, store data and the writeback value
    always_ff @(posedge clk) begin
        if (mem_start) begin
            dbus_adr    <= {result[xlen-1:2], 2'b00};
            dbus_sel    <= lane_sel;
            dbus_wdat   <= rs2_val << (result[1:0] * byte_bits);
            lane_offset <= result[1:0];
            if (!is_load && !is_store)
                rd_val <= result;
        end else if (dbus_cyc && dbus_ack && !dbus_we) begin
            rd_val <= load_val;
        end
    end

    assign mem_done = pass_done | (dbus_cyc & dbus_ack);

    a_sel_active: assert property (@(posedge clk) disable iff (reset)
        dbus_stb |-> dbus_sel != '0);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        dbus_stb |-> dbus_cyc);

endmodule

//--- stage_sequencer.sv
module stage_sequencer #(
    parameter riscv_isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ibus_ack,
    input  riscv_isa_pkg::word_t ibus_dat,
    output logic                 ibus_cyc,
    output logic                 ibus_stb,
    output riscv_isa_pkg::word_t ibus_adr,
    output riscv_isa_pkg::word_t instr,
    input  logic                 writes_rd,
    output logic                 mem_start,
    input  logic                 mem_done,
    output logic                 rd_we
);
    import riscv_isa_pkg::*;
    import core_pkg::*;

    stage_t stage;
    word_t  pc;

    // Fetch request held for the whole fetch stage
    assign ibus_cyc = (stage == STAGE_FETCH);
    assign ibus_stb = (stage == STAGE_FETCH);
    assign ibus_adr = pc;

    // Memory stage starts as execute hands over
    assign mem_start = (stage == STAGE_EXECUTE);
    assign rd_we     = (stage == STAGE_WRITEBACK) && writes_rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_FETCH;
            pc    <= reset_pc;
        end else begin
            case (stage)
                STAGE_FETCH: begin
                    if (ibus_ack)
                        stage <= STAGE_DECODE;
                end
                STAGE_DECODE: stage <= STAGE_EXECUTE;
                STAGE_EXECUTE: stage <= STAGE_MEMORY;
                STAGE_MEMORY: begin
                    // Waits on the load/store unit, stretched by dbus wait states
                    if (mem_done)
                        stage <= STAGE_WRITEBACK;
                end
                STAGE_WRITEBACK: begin
                    pc    <= pc + 32'd4;
                    stage <= STAGE_FETCH;
                end
                default: stage <= STAGE_FETCH;
            endcase
        end
    end

    // Instruction word, held until the next fetch completes
    always_ff @(posedge clk) begin
        if (stage == STAGE_FETCH && ibus_ack)
            instr <= ibus_dat;
    end

    a_ibus_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        ibus_stb |-> ibus_cyc);

    a_fetch_until_ack: assert property (@(posedge clk) disable iff (reset)
        (stage == STAGE_FETCH && !ibus_ack) |=> stage == STAGE_FETCH);

endmodule

//--- rv32i_core.sv
module rv32i_core #(
    parameter riscv_isa_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 ibus_cyc,
    output logic                 ibus_stb,
    output riscv_isa_pkg::word_t ibus_adr,
    input  riscv_isa_pkg::word_t ibus_dat,
    input  logic                 ibus_ack,
    output logic                 dbus_cyc,
    output logic                 dbus_stb,
    output logic                 dbus_we,
    output core_pkg::sel_t       dbus_sel,
    output riscv_isa_pkg::word_t dbus_adr,
    output riscv_isa_pkg::word_t dbus_wdat,
    input  riscv_isa_pkg::word_t dbus_rdat,
    input  logic                 dbus_ack
);
    import riscv_isa_pkg::*;

    word_t      instr;
    op_t        op;
    reg_index_t rs1;
    reg_index_t rs2;
    reg_index_t rd;
    word_t      imm;
    logic       writes_rd;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      result;
    logic       mem_start;
    logic       mem_done;
    logic       rd_we;
    word_t      rd_val;

    stage_sequencer #(.reset_pc(reset_pc)) u_sequencer (
        .clk, .reset, .ibus_ack, .ibus_dat, .ibus_cyc, .ibus_stb, .ibus_adr,
        .instr, .writes_rd, .mem_start, .mem_done, .rd_we
    );

    instr_decoder u_decoder (
        .instr, .op, .rs1, .rs2, .rd, .imm, .writes_rd
    );

    register_file u_regs (
        .clk, .reset, .rs1, .rs2, .rd, .rd_we, .rd_val, .rs1_val, .rs2_val
    );

    alu u_alu (
        .op, .rs1_val, .rs2_val, .imm, .result
    );

    load_store_unit u_lsu (
        .clk, .reset, .mem_start, .op, .result, .rs2_val,
        .dbus_cyc, .dbus_stb, .dbus_we, .dbus_sel, .dbus_adr, .dbus_wdat,
        .dbus_rdat, .dbus_ack, .mem_done, .rd_val
    );

endmodule

//--- tb_rv32i_core.sv
module tb_rv32i_core;

    localparam logic [31:0] prog_base  = 32'h0000_0400;
    localparam logic [31:0] data_base  = 32'h0000_2000;
    localparam int          imem_words = 512;
    localparam int          dmem_words = 256;

    typedef struct packed {
        logic [31:0] adr;
        logic [3:0]  sel;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        reset;
    logic        ibus_cyc;
    logic        ibus_stb;
    logic [31:0] ibus_adr;
    logic [31:0] ibus_dat;
    logic        ibus_ack;
    logic        dbus_cyc;
    logic        dbus_stb;
    logic        dbus_we;
    logic [3:0]  dbus_sel;
    logic [31:0] dbus_adr;
    logic [31:0] dbus_wdat;
    logic [31:0] dbus_rdat;
    logic        dbus_ack;

    logic [31:0] imem [imem_words];
    logic [31:0] dmem [dmem_words];
    store_t      exp_q [$];
    int          prog_len = 0;
    logic [11:0] next_off = 12'd0;
    int          test_count = 0;
    int          expected_accesses = 0;
    int          accesses = 0;
    int          checked = 0;
    int          total_stores;
    int          cycles = 0;
    int          limit;
    int          value_errors = 0;
    int          other_errors = 0;
    int          i_wait = -1;
    int          d_wait = -1;
    logic        fetch_seen = 1'b0;

    rv32i_core #(.reset_pc(prog_base)) UUT (
        .clk, .reset, .ibus_cyc, .ibus_stb, .ibus_adr, .ibus_dat, .ibus_ack,
        .dbus_cyc, .dbus_stb, .dbus_we, .dbus_sel, .dbus_adr, .dbus_wdat,
        .dbus_rdat, .dbus_ack
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction encoders
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    // Encodings outside the supported set that all target x3
    function automatic logic [31:0] unsupported(input int k);
        case (k % 4)
            0:       return enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3);
            1:       return enc_i({7'b0100000, 5'd3}, 5'd1, 3'b001, 5'd3, 7'b0010011);
            2:       return enc_i(12'h000, 5'd4, 3'b011, 5'd3, 7'b0000011);
            default: return {17'h1_2345, 3'b000, 5'd3, 7'b1111111};
        endcase
    endfunction

    // Words past the program carry an unused major opcode
    function automatic logic [31:0] instr_fill(input logic [31:0] adr);
        return ((adr * 32'h9e37_79b1) & 32'hffff_ff80) | 32'h0000_007f;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        logic [31:0] m;
        for (int i = 0; i < 4; i++)
            m[8*i +: 8] = {8{sel[i]}};
        return m;
    endfunction

    // Expected results from the RV32I rules
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input logic [31:0] word, input logic [1:0] size,
                                             input logic uns, input logic [1:0] off);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (size)
            2'd0:    return uns ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            2'd1:    return uns ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    function automatic store_t predict_store(input logic [1:0] size, input logic [31:0] addr,
                                             input logic [31:0] val);
        store_t s;
        s.adr  = {addr[31:2], 2'b00};
        s.data = val << (8 * addr[1:0]);
        case (size)
            2'd0:    s.sel = 4'b0001 << addr[1:0];
            2'd1:    s.sel = 4'b0011 << addr[1:0];
            default: s.sel = 4'b1111;
        endcase
        return s;
    endfunction

    // Program builder
    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
        logic [19:0] hi;
        // ADDI sign-extends, so the upper part absorbs bit 11
        hi = val[31:12] + 20'(val[11]);
        emit({hi, rd, 7'b0110111});
        emit(enc_i(val[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic emit_store(input logic [1:0] size, input logic [4:0] rs2,
                              input logic [11:0] off, input logic [31:0] val);
        emit(enc_s(off, rs2, 5'd4, {1'b0, size}));
        exp_q.push_back(predict_store(size, data_base + 32'(off), val));
        expected_accesses++;
    endtask

    task automatic store_fresh(input logic [4:0] rs2, input logic [31:0] val);
        emit_store(2'd2, rs2, next_off, val);
        next_off += 12'd4;
    endtask

    task automatic emit_load(input logic [2:0] f3, input logic [11:0] off);
        emit(enc_i(off, 5'd4, f3, 5'd3, 7'b0000011));
        expected_accesses++;
    endtask

    task automatic run_alu_test(input logic [2:0] f3, input logic use_imm, input logic alt);
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm12;
        a = $urandom;
        load_const(5'd1, a);
        if (use_imm) begin
            imm12 = 12'($urandom);
            if (f3 == 3'b001 || f3 == 3'b101)
                imm12 = {alt ? 7'b0100000 : 7'b0000000, imm12[4:0]};
            b = {{20{imm12[11]}}, imm12};
            emit(enc_i(imm12, 5'd1, f3, 5'd3, 7'b0010011));
        end else begin
            b = $urandom;
            load_const(5'd2, b);
            emit(enc_r(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, 5'd3));
        end
        emit(unsupported(test_count));
        test_count++;
        store_fresh(5'd3, alu_ref(f3, alt, a, b));
    endtask

    // A full word, a narrow store into it and every reload of those lanes
    task automatic lane_test(input logic [1:0] size, input logic [1:0] off);
        logic [31:0] w;
        logic [31:0] v;
        logic [31:0] merged;
        logic [11:0] base;
        store_t      s;
        w = $urandom;
        v = $urandom;
        base = next_off;
        next_off += 12'd4;
        load_const(5'd1, w);
        load_const(5'd2, v);
        emit_store(2'd2, 5'd1, base, w);
        emit_store(size, 5'd2, base + 12'(off), v);
        s = predict_store(size, 32'(off), v);
        merged = (w & ~lane_mask(s.sel)) | (s.data & lane_mask(s.sel));
        for (int uns = 0; uns < 2; uns++) begin
            emit_load({uns[0], size}, base + 12'(off));
            store_fresh(5'd3, load_ref(merged, size, uns[0], off));
        end
        emit_load(3'b010, base);
        store_fresh(5'd3, merged);
    endtask

    task automatic build_program();
        for (int i = 0; i < dmem_words; i++)
            dmem[i] = ((data_base + 32'(4 * i)) * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
        load_const(5'd4, data_base);
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int form = 0; form < 2; form++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 1 && !(f3 == 5 || (f3 == 0 && form == 0)))
                        continue;
                    run_alu_test(3'(f3), form == 1, alt == 1);
                end
            end
        end
        // x0 ignores writes
        emit(enc_i(12'h7ff, 5'd1, 3'b000, 5'd0, 7'b0010011));
        emit({20'hfffff, 5'd0, 7'b0110111});
        store_fresh(5'd0, 32'h0);
        for (int size = 0; size < 2; size++) begin
            for (int off = 0; off < 4; off += size + 1)
                lane_test(2'(size), 2'(off));
        end
    endtask

    // Instruction memory
    always @(negedge clk) begin
        logic [31:0] widx;
        if (reset) begin
            ibus_ack <= 1'b0;
        end else if (ibus_ack) begin
            ibus_ack <= 1'b0;
        end else if (ibus_cyc && ibus_stb) begin
            if (!fetch_seen) begin
                fetch_seen = 1'b1;
                if (ibus_adr !== prog_base) begin
                    value_errors++;
                    $display("[ERROR] %0t ibus_adr expected %h got %h",
                             $time, prog_base, ibus_adr);
                end
            end
            if (i_wait < 0)
                i_wait = int'($urandom % 4);
            if (i_wait == 0) begin
                i_wait = -1;
                widx = (ibus_adr - prog_base) >> 2;
                ibus_dat <= (widx < 32'(prog_len)) ? imem[widx] : instr_fill(ibus_adr);
                ibus_ack <= 1'b1;
            end else begin
                i_wait--;
            end
        end
    end

    // Data memory
    always @(negedge clk) begin
        logic [31:0] widx;
        logic [31:0] m;
        if (reset) begin
            if (dbus_cyc !== 1'b0) begin
                other_errors++;
                $display("Data-bus cycle seen during reset at %0t", $time);
            end
            dbus_ack <= 1'b0;
        end else if (dbus_ack) begin
            dbus_ack <= 1'b0;
        end else if (dbus_cyc && dbus_stb) begin
            if (d_wait < 0)
                d_wait = int'($urandom % 4);
            if (d_wait == 0) begin
                d_wait = -1;
                widx = (dbus_adr - data_base) >> 2;
                if (widx >= 32'(dmem_words)) begin
                    other_errors++;
                    $display("Data access outside data memory at %0t, address %h",
                             $time, dbus_adr);
                    dbus_rdat <= 32'h0;
                end else if (dbus_we) begin
                    m = lane_mask(dbus_sel);
                    dmem[widx[7:0]] = (dmem[widx[7:0]] & ~m) | (dbus_wdat & m);
                end else begin
                    dbus_rdat <= dmem[widx[7:0]];
                end
                dbus_ack <= 1'b1;
            end else begin
                d_wait--;
            end
        end
    end

    // Compare every acknowledged write with the next expected store
    always @(posedge clk) begin
        store_t      e;
        logic [31:0] m;
        if (!reset) begin
            cycles++;
            if (dbus_cyc && dbus_stb && dbus_ack) begin
                accesses++;
                if (dbus_we && exp_q.size() == 0) begin
                    other_errors++;
                    $display("Unexpected data-bus write at %0t to %h", $time, dbus_adr);
                end else if (dbus_we) begin
                    e = exp_q.pop_front();
                    m = lane_mask(e.sel);
                    checked++;
                    if (dbus_adr !== e.adr) begin
                        value_errors++;
                        $display("[ERROR] %0t dbus_adr expected %h got %h",
                                 $time, e.adr, dbus_adr);
                    end
                    if (dbus_sel !== e.sel) begin
                        value_errors++;
                        $display("[ERROR] %0t dbus_sel expected %b got %b",
                                 $time, e.sel, dbus_sel);
                    end
                    if ((dbus_wdat & m) !== (e.data & m)) begin
                        value_errors++;
                        $display("[ERROR] %0t dbus_wdat expected %h got %h",
                                 $time, e.data & m, dbus_wdat & m);
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hbfdf21c1));
        reset     <= 1'b1;
        ibus_ack  <= 1'b0;
        ibus_dat  <= 32'h0;
        dbus_ack  <= 1'b0;
        dbus_rdat <= 32'h0;
        build_program();
        total_stores = exp_q.size();
        limit = 25 * prog_len;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
        while (checked < total_stores && cycles < limit)
            @(negedge clk);
        if (cycles >= limit) begin
            other_errors++;
            $display("Timeout, the run hung after %0d cycles with %0d of %0d stores seen",
                     cycles, checked, total_stores);
        end
        if (accesses != expected_accesses) begin
            other_errors++;
            $display("Data-bus access count wrong, expected %0d but saw %0d",
                     expected_accesses, accesses);
        end
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- verilog.f
riscv_isa_pkg.sv
core_pkg.sv
instr_decoder.sv
register_file.sv
alu.sv
load_store_unit.sv
stage_sequencer.sv
rv32i_core.sv
tb_rv32i_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --assert -Wno-fatal
TOP       := tb_rv32i_core
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard *.sv)
LOG       := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
